//--- logic/key_pkg.sv
// Key input definitions: digit code width and operator key codes
package key_pkg;

    // Width of one decimal digit code
    parameter int KEY_W = 4;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

endpackage

//--- logic/calc_pkg.sv
// Computation definitions: store commands, arithmetic select, operand select, digit base
package calc_pkg;

    // Operand store commands
    typedef enum logic [2:0] {
        ST_NONE,
        ST_NEG,
        ST_LOAD_PRODUCT,
        ST_ADD_DIGIT,
        ST_CLEAR
    } store_cmd_t;

    typedef enum logic {
        OPND_A,
        OPND_B
    } opnd_sel_t;

    typedef enum logic {
        ARITH_ADD,
        ARITH_SUB
    } arith_t;

    // Each entered digit shifts the operand by one decimal place
    parameter int DIGIT_BASE = 10;

endpackage

//--- logic/key_capture.sv
// Key front end holding one pending digit, operator or equals key for the sequencer
`timescale 1ns/1ns

module key_capture (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     key_strobe,
    input  logic [key_pkg::KEY_W-1:0] key_digit,
    input  logic                     op_strobe,
    input  key_pkg::op_t             op_code,
    input  logic                     eq_strobe,
    input  logic                     key_read,
    input  logic                     seq_idle,
    output logic                     digit_pending,
    output logic [key_pkg::KEY_W-1:0] digit,
    output logic                     op_pending,
    output key_pkg::op_t             op,
    output logic                     eq_pending,
    output logic                     key_busy
);

    logic any_pending;

    assign any_pending = digit_pending | op_pending | eq_pending;
    // Busy covers the pending key and the whole action it started
    assign key_busy = any_pending | ~seq_idle;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            digit_pending <= 1'b0;
            op_pending    <= 1'b0;
            eq_pending    <= 1'b0;
        end else if (key_read) begin
            digit_pending <= 1'b0;
            op_pending    <= 1'b0;
            eq_pending    <= 1'b0;
        end else if (!key_busy) begin
            digit_pending <= key_strobe;
            op_pending    <= op_strobe;
            eq_pending    <= eq_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (!key_busy && key_strobe) begin
            digit <= key_digit;
        end
        if (!key_busy && op_strobe) begin
            op <= op_code;
        end
    end

    a_read_has_key: assert property (@(posedge clk) disable iff (!nRST)
        key_read |-> any_pending);

endmodule

//--- logic/operand_store.sv
// Two sign-magnitude operand registers updated by sequencer commands
`timescale 1ns/1ns

module operand_store #(
    parameter int NUM_W = 16
) (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_pkg::store_cmd_t      store_cmd,
    input  calc_pkg::opnd_sel_t       store_sel,
    input  logic [key_pkg::KEY_W-1:0] digit,
    input  logic [NUM_W-1:0]          product,
    output logic [NUM_W-1:0]          operand_a,
    output logic [NUM_W-1:0]          operand_b
);

    localparam int MAG_W = NUM_W - 1;

    function automatic logic [NUM_W-1:0] apply_cmd(input logic [NUM_W-1:0] cur);
        logic [MAG_W-1:0] mag_sum;
        mag_sum = cur[MAG_W-1:0] + MAG_W'(digit);
        case (store_cmd)
            calc_pkg::ST_NEG:
                apply_cmd = {~cur[NUM_W-1], cur[MAG_W-1:0]};
            // Product sign is ignored, the operand keeps its own
            calc_pkg::ST_LOAD_PRODUCT:
                apply_cmd = {cur[NUM_W-1], product[MAG_W-1:0]};
            calc_pkg::ST_ADD_DIGIT:
                apply_cmd = {cur[NUM_W-1], mag_sum};
            default:
                apply_cmd = cur;
        endcase
    endfunction

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (store_cmd == calc_pkg::ST_CLEAR) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (store_sel == calc_pkg::OPND_A) begin
            operand_a <= apply_cmd(operand_a);
        end else begin
            operand_b <= apply_cmd(operand_b);
        end
    end

endmodule

//--- logic/calc_sequencer.sv
// Calculator FSM for digit entry, operator latching, arithmetic start and result display
`timescale 1ns/1ns

module calc_sequencer #(
    parameter int NUM_W = 16
) (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      digit_pending,
    input  logic [key_pkg::KEY_W-1:0] digit,
    input  logic                      op_pending,
    input  key_pkg::op_t              op,
    input  logic                      eq_pending,
    output logic                      key_read,
    output logic                      seq_idle,
    output calc_pkg::store_cmd_t      store_cmd,
    output calc_pkg::opnd_sel_t       store_sel,
    output logic [key_pkg::KEY_W-1:0] latched_digit,
    input  logic [NUM_W-1:0]          operand_a,
    input  logic [NUM_W-1:0]          operand_b,
    output logic                      start_addsub,
    output calc_pkg::arith_t          arith,
    output logic [NUM_W-1:0]          addsub_in_a,
    output logic [NUM_W-1:0]          addsub_in_b,
    input  logic                      addsub_finish,
    input  logic [NUM_W-1:0]          addsub_out,
    output logic                      start_mult,
    output logic [NUM_W-1:0]          mult_a,
    output logic [NUM_W-1:0]          mult_b,
    input  logic                      mult_finish,
    input  logic [NUM_W-1:0]          mult_out,
    output logic                      complete,
    output logic [NUM_W-1:0]          display_output
);

    typedef enum logic [3:0] {
        ENTER_A, MUL_A, ADD_DIGIT_A,
        ENTER_B, MUL_B, ADD_DIGIT_B,
        COMPUTE_START, COMPUTE_WAIT, SHOW_RESULT
    } state_t;

    state_t       state;
    key_pkg::op_t latched_op;
    logic         key_new;
    logic         is_mul;

    // A key stays pending for one cycle after key_read, so skip it then
    assign key_new  = (digit_pending | op_pending | eq_pending) & ~key_read;
    assign seq_idle = state inside {ENTER_A, ENTER_B};
    assign store_sel = (state inside {ENTER_B, MUL_B, ADD_DIGIT_B}) ?
                       calc_pkg::OPND_B : calc_pkg::OPND_A;
    assign is_mul = (latched_op == key_pkg::OP_MUL);

    assign arith = (latched_op == key_pkg::OP_SUB) ? calc_pkg::ARITH_SUB : calc_pkg::ARITH_ADD;
    assign addsub_in_a = operand_a;
    assign addsub_in_b = operand_b;
    // Multiplier is shared between digit entry and the final product
    assign mult_a = (state == MUL_B) ? operand_b : operand_a;
    assign mult_b = (state inside {MUL_A, MUL_B}) ? NUM_W'(calc_pkg::DIGIT_BASE) : operand_b;

    always_comb begin
        store_cmd = calc_pkg::ST_NONE;
        case (state)
            ENTER_A, ENTER_B: begin
                if (key_new && op_pending && op == key_pkg::OP_NEG) begin
                    store_cmd = calc_pkg::ST_NEG;
                end else if (key_new && eq_pending && state == ENTER_A) begin
                    // Stray equals drops the partial entry
                    store_cmd = calc_pkg::ST_CLEAR;
                end
            end
            MUL_A, MUL_B: begin
                if (mult_finish) begin
                    store_cmd = calc_pkg::ST_LOAD_PRODUCT;
                end
            end
            ADD_DIGIT_A, ADD_DIGIT_B: store_cmd = calc_pkg::ST_ADD_DIGIT;
            SHOW_RESULT:              store_cmd = calc_pkg::ST_CLEAR;
            default:                  store_cmd = calc_pkg::ST_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_A;
            latched_op     <= key_pkg::OP_NONE;
            key_read       <= 1'b0;
            start_addsub   <= 1'b0;
            start_mult     <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            key_read     <= 1'b0;
            start_addsub <= 1'b0;
            start_mult   <= 1'b0;
            complete     <= 1'b0;
            case (state)
                ENTER_A, ENTER_B: begin
                    if (key_new) begin
                        key_read <= 1'b1;
                    end
                    if (key_new && digit_pending) begin
                        start_mult <= 1'b1;
                        state      <= (state == ENTER_A) ? MUL_A : MUL_B;
                    end else if (key_new && eq_pending && state == ENTER_B) begin
                        state <= COMPUTE_START;
                    end else if (key_new && op_pending && state == ENTER_A &&
                                 op inside {key_pkg::OP_ADD, key_pkg::OP_SUB,
                                            key_pkg::OP_MUL}) begin
                        latched_op <= op;
                        state      <= ENTER_B;
                    end
                end
                MUL_A: if (mult_finish) state <= ADD_DIGIT_A;
                MUL_B: if (mult_finish) state <= ADD_DIGIT_B;
                ADD_DIGIT_A: state <= ENTER_A;
                ADD_DIGIT_B: state <= ENTER_B;
                COMPUTE_START: begin
                    start_mult   <= is_mul;
                    start_addsub <= ~is_mul;
                    state        <= COMPUTE_WAIT;
                end
                COMPUTE_WAIT: begin
                    if (addsub_finish || mult_finish) begin
                        display_output <= is_mul ? mult_out : addsub_out;
                        complete       <= 1'b1;
                        state          <= SHOW_RESULT;
                    end
                end
                SHOW_RESULT: begin
                    latched_op <= key_pkg::OP_NONE;
                    state      <= ENTER_A;
                end
                default: state <= ENTER_A;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (seq_idle && key_new && digit_pending) begin
            latched_digit <= digit;
        end
    end

    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete);

endmodule

//--- logic/addsub_unit.sv
// Two-cycle sign-magnitude adder/subtractor
`timescale 1ns/1ns

module addsub_unit #(
    parameter int NUM_W = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  calc_pkg::arith_t arith,
    input  logic [NUM_W-1:0] in_a,
    input  logic [NUM_W-1:0] in_b,
    output logic [NUM_W-1:0] out,
    output logic             finish
);

    localparam int MAG_W = NUM_W - 1;

    logic             sign_b;
    logic             a_ge_b;
    logic             stage1;
    logic             same_sign;
    logic             sign_big;
    logic [MAG_W-1:0] mag_big;
    logic [MAG_W-1:0] mag_small;
    logic [MAG_W-1:0] mag_res;

    // Subtraction is addition with the second sign flipped
    assign sign_b = in_b[NUM_W-1] ^ (arith == calc_pkg::ARITH_SUB);
    assign a_ge_b = in_a[MAG_W-1:0] >= in_b[MAG_W-1:0];
    assign mag_res = same_sign ? mag_big + mag_small : mag_big - mag_small;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            stage1 <= 1'b0;
            finish <= 1'b0;
        end else begin
            stage1 <= start;
            finish <= stage1;
        end
    end

    // Compare on the start edge, form the result on the next
    always_ff @(posedge clk) begin
        if (start) begin
            same_sign <= (in_a[NUM_W-1] == sign_b);
            sign_big  <= a_ge_b ? in_a[NUM_W-1] : sign_b;
            mag_big   <= a_ge_b ? in_a[MAG_W-1:0] : in_b[MAG_W-1:0];
            mag_small <= a_ge_b ? in_b[MAG_W-1:0] : in_a[MAG_W-1:0];
        end
        if (stage1) begin
            out <= {sign_big & (|mag_res), mag_res};
        end
    end

endmodule

//--- logic/shift_multiplier.sv
// Iterative shift-add sign-magnitude multiplier
`timescale 1ns/1ns

module shift_multiplier #(
    parameter int NUM_W = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic [NUM_W-1:0] in_a,
    input  logic [NUM_W-1:0] in_b,
    output logic [NUM_W-1:0] out,
    output logic             finish
);

    localparam int MAG_W = NUM_W - 1;
    localparam int CNT_W = $clog2(NUM_W);

    typedef enum logic {IDLE, RUN} mstate_t;

    mstate_t          state;
    logic [CNT_W-1:0] count;
    logic [MAG_W-1:0] mcand;
    logic [MAG_W-1:0] mplier;
    logic [MAG_W-1:0] acc;
    logic [MAG_W-1:0] acc_next;
    logic             sign;

    // High product bits fall off, giving the magnitude wrap
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (state == IDLE && start) begin
                state <= RUN;
                count <= '0;
            end else if (state == RUN) begin
                count <= count + 1'b1;
                if (count == CNT_W'(MAG_W - 1)) begin
                    state  <= IDLE;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            mcand  <= in_a[MAG_W-1:0];
            mplier <= in_b[MAG_W-1:0];
            acc    <= '0;
            sign   <= in_a[NUM_W-1] ^ in_b[NUM_W-1];
        end else if (state == RUN) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (count == CNT_W'(MAG_W - 1)) begin
                out <= {sign & (|acc_next), acc_next};
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!nRST)
        start |-> state == IDLE);

endmodule

//--- logic/calc_top.sv
// Keypad calculator core top level
`timescale 1ns/1ns

module calc_top #(
    parameter int NUM_W = 16
) (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      key_strobe,
    input  logic [key_pkg::KEY_W-1:0] key_digit,
    input  logic                      op_strobe,
    input  key_pkg::op_t              op_code,
    input  logic                      eq_strobe,
    output logic                      key_busy,
    output logic                      complete,
    output logic [NUM_W-1:0]          display_output
);

    logic                      digit_pending;
    logic                      op_pending;
    logic                      eq_pending;
    logic [key_pkg::KEY_W-1:0] digit;
    key_pkg::op_t              op;
    logic                      key_read;
    logic                      seq_idle;
    calc_pkg::store_cmd_t      store_cmd;
    calc_pkg::opnd_sel_t       store_sel;
    logic [key_pkg::KEY_W-1:0] latched_digit;
    logic [NUM_W-1:0]          operand_a;
    logic [NUM_W-1:0]          operand_b;
    logic                      start_addsub;
    calc_pkg::arith_t          arith;
    logic [NUM_W-1:0]          addsub_in_a;
    logic [NUM_W-1:0]          addsub_in_b;
    logic                      addsub_finish;
    logic [NUM_W-1:0]          addsub_out;
    logic                      start_mult;
    logic [NUM_W-1:0]          mult_a;
    logic [NUM_W-1:0]          mult_b;
    logic                      mult_finish;
    logic [NUM_W-1:0]          mult_out;

    key_capture u_capture (
        .clk(clk), .nRST(nRST),
        .key_strobe(key_strobe), .key_digit(key_digit),
        .op_strobe(op_strobe), .op_code(op_code), .eq_strobe(eq_strobe),
        .key_read(key_read), .seq_idle(seq_idle),
        .digit_pending(digit_pending), .digit(digit),
        .op_pending(op_pending), .op(op), .eq_pending(eq_pending),
        .key_busy(key_busy)
    );

    calc_sequencer #(.NUM_W(NUM_W)) u_sequencer (
        .clk(clk), .nRST(nRST),
        .digit_pending(digit_pending), .digit(digit),
        .op_pending(op_pending), .op(op), .eq_pending(eq_pending),
        .key_read(key_read), .seq_idle(seq_idle),
        .store_cmd(store_cmd), .store_sel(store_sel), .latched_digit(latched_digit),
        .operand_a(operand_a), .operand_b(operand_b),
        .start_addsub(start_addsub), .arith(arith),
        .addsub_in_a(addsub_in_a), .addsub_in_b(addsub_in_b),
        .addsub_finish(addsub_finish), .addsub_out(addsub_out),
        .start_mult(start_mult), .mult_a(mult_a), .mult_b(mult_b),
        .mult_finish(mult_finish), .mult_out(mult_out),
        .complete(complete), .display_output(display_output)
    );

    operand_store #(.NUM_W(NUM_W)) u_store (
        .clk(clk), .nRST(nRST),
        .store_cmd(store_cmd), .store_sel(store_sel),
        .digit(latched_digit), .product(mult_out),
        .operand_a(operand_a), .operand_b(operand_b)
    );

    addsub_unit #(.NUM_W(NUM_W)) u_addsub (
        .clk(clk), .nRST(nRST),
        .start(start_addsub), .arith(arith),
        .in_a(addsub_in_a), .in_b(addsub_in_b),
        .out(addsub_out), .finish(addsub_finish)
    );

    shift_multiplier #(.NUM_W(NUM_W)) u_mult (
        .clk(clk), .nRST(nRST),
        .start(start_mult), .in_a(mult_a), .in_b(mult_b),
        .out(mult_out), .finish(mult_finish)
    );

endmodule

//--- include/calc_ref.svh
// Calculator reference model: sign-magnitude digit entry, add, subtract, multiply and the LCG
`ifndef CALC_REF_SVH
`define CALC_REF_SVH

localparam int MAG_W = NUM_W - 1;

// Magnitude wraps by truncation, a zero result never carries a sign
function automatic logic [NUM_W-1:0] make_result(input logic sign, input longint unsigned mag);
    make_result = {sign & (mag[MAG_W-1:0] != 0), mag[MAG_W-1:0]};
endfunction

// New digit shifts one decimal place, the operand keeps its sign
function automatic logic [NUM_W-1:0] entry_append(input logic [NUM_W-1:0] v, input int d);
    longint unsigned mag;
    mag = 64'(v[MAG_W-1:0]) * 10 + 64'(d);
    entry_append = {v[NUM_W-1], mag[MAG_W-1:0]};
endfunction

function automatic logic [NUM_W-1:0] flip_sign(input logic [NUM_W-1:0] v);
    flip_sign = {~v[NUM_W-1], v[MAG_W-1:0]};
endfunction

function automatic logic [NUM_W-1:0] sum_or_diff(input logic [NUM_W-1:0] a,
        input logic [NUM_W-1:0] b, input logic subtract);
    logic            sb;
    longint unsigned ma;
    longint unsigned mb;
    sb = b[NUM_W-1] ^ subtract;
    ma = 64'(a[MAG_W-1:0]);
    mb = 64'(b[MAG_W-1:0]);
    // Different signs take the larger magnitude's sign
    if (a[NUM_W-1] == sb) begin
        sum_or_diff = make_result(sb, ma + mb);
    end else if (ma >= mb) begin
        sum_or_diff = make_result(a[NUM_W-1], ma - mb);
    end else begin
        sum_or_diff = make_result(sb, mb - ma);
    end
endfunction

function automatic logic [NUM_W-1:0] expected_result(input logic [NUM_W-1:0] a,
        input logic [NUM_W-1:0] b, input key_pkg::op_t op);
    case (op)
        key_pkg::OP_MUL: expected_result = make_result(a[NUM_W-1] ^ b[NUM_W-1],
                                                       64'(a[MAG_W-1:0]) * 64'(b[MAG_W-1:0]));
        key_pkg::OP_SUB: expected_result = sum_or_diff(a, b, 1'b1);
        default:         expected_result = sum_or_diff(a, b, 1'b0);
    endcase
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- bench/calc_tb.sv
// Calculator testbench with directed and random key sequences checked against a reference model
`timescale 1ns/1ns

module calc_tb;

    localparam int NUM_W = 16;
    localparam int WAIT_LIMIT = 200;
    localparam int QUIET_CYCLES = 60;

    logic                      clk = 1'b0;
    logic                      nRST;
    logic                      key_strobe;
    logic [key_pkg::KEY_W-1:0] key_digit;
    logic                      op_strobe;
    key_pkg::op_t              op_code;
    logic                      eq_strobe;
    logic                      key_busy;
    logic                      complete;
    logic [NUM_W-1:0]          display_output;

    logic [NUM_W-1:0] expect_q[$];
    int               calcs_started = 0;
    int               results_seen = 0;
    logic [31:0]      seed = 32'he2dd_abfd;
    int               ten_pow[4] = '{10, 100, 1000, 10000};
    key_pkg::op_t     ops[3] = '{key_pkg::OP_ADD, key_pkg::OP_SUB, key_pkg::OP_MUL};

    `include "calc_ref.svh"

    calc_top #(.NUM_W(NUM_W)) UUT (
        .clk(clk), .nRST(nRST),
        .key_strobe(key_strobe), .key_digit(key_digit),
        .op_strobe(op_strobe), .op_code(op_code), .eq_strobe(eq_strobe),
        .key_busy(key_busy), .complete(complete), .display_output(display_output)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_value(input string name, input logic [NUM_W-1:0] got,
                                input logic [NUM_W-1:0] want);
        assert (got === want) else report_failure($sformatf(
            "CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want));
    endtask

    function automatic int draw(input int limit);
        seed = lcg_next(seed);
        draw = int'(seed[30:16]) % limit;
    endfunction

    // Kind 0 is a digit, 1 an operator, 2 equals; entered and left at edge + 1 ns
    task automatic drive_key(input int kind, input int code);
        key_digit  = 4'(code);
        op_code    = key_pkg::op_t'(3'(code));
        key_strobe = (kind == 0);
        op_strobe  = (kind == 1);
        eq_strobe  = (kind == 2);
        @(posedge clk);
        #1;
        key_strobe = 1'b0;
        op_strobe  = 1'b0;
        eq_strobe  = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (key_busy) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) report_failure("Timed out waiting for key_busy to fall");
        end
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (results_seen < calcs_started) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) report_failure("Timed out waiting for complete");
        end
    endtask

    task automatic press_digit(input int d);
        wait_idle();
        drive_key(0, d);
    endtask

    task automatic press_op(input key_pkg::op_t o);
        wait_idle();
        drive_key(1, int'(o));
    endtask

    task automatic press_eq();
        wait_idle();
        drive_key(2, 0);
    endtask

    task automatic finish_calc(input logic [NUM_W-1:0] want);
        expect_q.push_back(want);
        calcs_started++;
        press_eq();
        wait_result();
    endtask

    task automatic enter_operand(input int value, input bit neg, output logic [NUM_W-1:0] model);
        int digits[$];
        int v;
        v = value;
        model = '0;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            press_digit(digits[i]);
            model = entry_append(model, digits[i]);
        end
        if (neg) begin
            press_op(key_pkg::OP_NEG);
            model = flip_sign(model);
        end
    endtask

    task automatic run_calc(input int a, input bit a_neg, input key_pkg::op_t op,
                            input int b, input bit b_neg);
        logic [NUM_W-1:0] ma;
        logic [NUM_W-1:0] mb;
        enter_operand(a, a_neg, ma);
        press_op(op);
        enter_operand(b, b_neg, mb);
        finish_calc(expected_result(ma, mb, op));
    endtask

    // Every complete pulse is matched with the oldest outstanding calculation
    always @(negedge clk) begin
        if (nRST && complete) begin
            if (expect_q.size() == 0) begin
                report_failure("complete pulsed with no calculation outstanding");
            end else begin
                expect_value("display_output", display_output, expect_q.pop_front());
                results_seen++;
            end
        end
    end

    initial begin
        int           a_val;
        int           b_val;
        bit           a_neg;
        bit           b_neg;
        key_pkg::op_t op_pick;
        nRST       = 1'b0;
        key_strobe = 1'b0;
        key_digit  = '0;
        op_strobe  = 1'b0;
        op_code    = key_pkg::OP_NONE;
        eq_strobe  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        nRST = 1'b1;
        expect_value("display_output", display_output, '0);
        expect_value("complete", 16'(complete), '0);
        expect_value("key_busy", 16'(key_busy), '0);

        run_calc(123, 0, key_pkg::OP_ADD, 45, 0);
        expect_value("display_output", display_output, 16'd168);
        run_calc(123, 0, key_pkg::OP_SUB, 45, 0);
        expect_value("display_output", display_output, 16'd78);
        run_calc(12, 1, key_pkg::OP_MUL, 7, 0);
        expect_value("display_output", display_output, 16'h8054);
        run_calc(5, 0, key_pkg::OP_SUB, 9, 0);
        expect_value("display_output", display_output, 16'h8004);
        run_calc(7, 0, key_pkg::OP_SUB, 7, 0);
        expect_value("display_output", display_output, 16'h0000);
        run_calc(999, 0, key_pkg::OP_MUL, 999, 0);
        expect_value("display_output", display_output, 16'd14961);
        run_calc(999, 1, key_pkg::OP_MUL, 999, 0);
        expect_value("display_output", display_output, 16'hBA71);

        // Strobes while busy must be dropped, giving 23 + 4
        press_digit(2);
        expect_value("key_busy", 16'(key_busy), 16'd1);
        drive_key(0, 9);
        repeat (4) @(posedge clk);
        #1;
        expect_value("key_busy", 16'(key_busy), 16'd1);
        drive_key(2, 0);
        press_digit(3);
        drive_key(1, int'(key_pkg::OP_MUL));
        press_op(key_pkg::OP_ADD);
        press_digit(4);
        finish_calc(16'd27);
        expect_value("display_output", display_output, 16'd27);

        // Equals without an operator gives no result and drops the entry
        press_digit(3);
        press_eq();
        wait_idle();
        repeat (QUIET_CYCLES) @(posedge clk);
        #1;
        expect_value("display_output", display_output, 16'd27);
        run_calc(4, 0, key_pkg::OP_ADD, 5, 0);
        expect_value("display_output", display_output, 16'd9);

        for (int i = 0; i < 200; i++) begin
            a_val   = draw(ten_pow[draw(4)]);
            a_neg   = (draw(2) == 1);
            op_pick = ops[draw(3)];
            b_val   = draw(ten_pow[draw(4)]);
            b_neg   = (draw(2) == 1);
            run_calc(a_val, a_neg, op_pick, b_val, b_neg);
        end

        if (results_seen == calcs_started && expect_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_failure("Number of results does not match the calculations started");
        end
    end

endmodule

//--- all.f
+incdir+include
logic/key_pkg.sv
logic/calc_pkg.sv
logic/key_capture.sv
logic/operand_store.sv
logic/calc_sequencer.sv
logic/addsub_unit.sv
logic/shift_multiplier.sv
logic/calc_top.sv
bench/calc_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timescale 1ns/1ns -Wno-fatal --top-module calc_tb \
		-f all.f -Mdir obj_dir -o calc_sim
	./obj_dir/calc_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "FAIL: run did not finish"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
